//--- include/display_consts.svh
`ifndef DISPLAY_CONSTS_SVH
`define DISPLAY_CONSTS_SVH

// ====================
// ascii codes
// ====================
`define DISP_ASC_SPACE 8'd32
`define DISP_ASC_CR 8'd13
`define DISP_ASC_LF 8'd10
`define DISP_ASC_ZERO 8'd48

// ====================
// text layout
// ====================
`define DISP_COL_WIDTH 10   // padded width of one matrix element
`define DISP_MAX_DIGITS 10  // widest 32-bit decimal

// uart bit period in clocks
`define DISP_CLKS_PER_BIT 8

`endif

//--- verilog/display_pkg.sv
`default_nettype none

package display_pkg;

    // storage data word, also matrix dims and scalar value
    typedef logic [31:0] word_t;

    // storage address
    typedef logic [8:0] addr_t;

    // one ascii character on the serial line
    typedef logic [7:0] char_t;

    // display commands, other codes finish without output
    typedef enum logic [2:0] {
        MODE_MATRIX = 3'd0,
        MODE_SCALAR = 3'd4
    } disp_mode_t;

endpackage

`default_nettype wire

//--- verilog/uart_tx.sv
`default_nettype none

`include "display_consts.svh"

module uart_tx
    import display_pkg::*;
#(
    parameter int CLKS_PER_BIT = `DISP_CLKS_PER_BIT
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  i_tx_en,
    input  char_t i_tx_data,
    output logic  o_tx,
    output logic  o_ready
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    logic [9:0]       shift_q;   // stop, data lsb first, start
    logic [CNT_W-1:0] clk_cnt_q;
    logic [3:0]       bit_cnt_q;
    logic             busy_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_q   <= '1;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            busy_q    <= 1'b0;
        end else if (!busy_q) begin
            if (i_tx_en) begin
                shift_q   <= {1'b1, i_tx_data, 1'b0};
                clk_cnt_q <= '0;
                bit_cnt_q <= '0;
                busy_q    <= 1'b1;
            end
        end else if (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt_q <= '0;
            shift_q   <= {1'b1, shift_q[9:1]};  // refill with idle level
            if (bit_cnt_q == 4'd9) begin
                busy_q <= 1'b0;                 // stop bit done
            end else begin
                bit_cnt_q <= bit_cnt_q + 4'd1;
            end
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
    end

    assign o_tx = shift_q[0];

    // a strobe in flight already counts as busy
    assign o_ready = ~busy_q & ~i_tx_en;

endmodule

`default_nettype wire

//--- verilog/dec_formatter.sv
`default_nettype none

`include "display_consts.svh"

module dec_formatter
    import display_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  i_start,
    input  word_t i_value,
    input  logic  i_pad_en,
    input  logic  i_tx_ready,
    output char_t o_char,
    output logic  o_char_en,
    output logic  o_done
);

    localparam int PTR_W = $clog2(`DISP_MAX_DIGITS);

    typedef enum logic [2:0] {
        F_IDLE,
        F_CONVERT,
        F_SEND,
        F_PAD,
        F_FINISH
    } fmt_state_t;

    fmt_state_t       state_q;
    char_t            dig_buf [`DISP_MAX_DIGITS];  // least significant digit at 0
    logic [PTR_W-1:0] ptr_q;
    word_t            work_q;
    logic [3:0]       out_cnt_q;                   // chars sent for this value
    logic             pad_q;
    char_t            char_q;
    logic             char_en_q;

    always_ff @(posedge clk) begin
        if (state_q == F_CONVERT) begin
            dig_buf[ptr_q] <= char_t'(work_q % 32'd10) + `DISP_ASC_ZERO;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= F_IDLE;
            ptr_q     <= '0;
            work_q    <= '0;
            out_cnt_q <= '0;
            pad_q     <= 1'b0;
            char_q    <= `DISP_ASC_SPACE;
            char_en_q <= 1'b0;
        end else begin
            char_en_q <= 1'b0;
            case (state_q)
                F_IDLE: begin
                    if (i_start) begin
                        work_q    <= i_value;
                        ptr_q     <= '0;
                        out_cnt_q <= '0;
                        pad_q     <= i_pad_en;
                        state_q   <= F_CONVERT;
                    end
                end
                // one digit per clock
                F_CONVERT: begin
                    if (work_q < 32'd10) begin
                        state_q <= F_SEND;
                    end else begin
                        work_q <= work_q / 32'd10;
                        ptr_q  <= ptr_q + 1'b1;
                    end
                end
                // play back msd first
                F_SEND: begin
                    if (i_tx_ready) begin
                        char_q    <= dig_buf[ptr_q];
                        char_en_q <= 1'b1;
                        out_cnt_q <= out_cnt_q + 4'd1;
                        if (ptr_q == '0) begin
                            state_q <= F_PAD;
                        end else begin
                            ptr_q <= ptr_q - 1'b1;
                        end
                    end
                end
                F_PAD: begin
                    if (pad_q && out_cnt_q < 4'(`DISP_COL_WIDTH)) begin
                        if (i_tx_ready) begin
                            char_q    <= `DISP_ASC_SPACE;
                            char_en_q <= 1'b1;
                            out_cnt_q <= out_cnt_q + 4'd1;
                        end
                    end else begin
                        state_q <= F_FINISH;
                    end
                end
                default: state_q <= F_IDLE;  // finish lasts one cycle
            endcase
        end
    end

    assign o_char    = char_q;
    assign o_char_en = char_en_q;
    assign o_done    = (state_q == F_FINISH);

endmodule

`default_nettype wire

//--- verilog/matrix_walker.sv
`default_nettype none

module matrix_walker
    import display_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  i_load,
    input  logic  i_advance,
    input  addr_t i_base_addr,
    input  word_t i_n,
    input  word_t i_m,
    output addr_t o_addr,
    output logic  o_last_col,
    output logic  o_last_row
);

    word_t row_q;
    word_t col_q;
    word_t row_d;
    word_t col_d;
    addr_t addr_q;

    assign o_last_col = (col_q == i_n - 32'd1);
    assign o_last_row = (row_q == i_m - 32'd1);

    // next position, row major
    always_comb begin
        row_d = row_q;
        col_d = col_q;
        if (i_load) begin
            row_d = '0;
            col_d = '0;
        end else if (i_advance) begin
            if (o_last_col) begin
                col_d = '0;
                row_d = row_q + 32'd1;
            end else begin
                col_d = col_q + 32'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q  <= '0;
            col_q  <= '0;
            addr_q <= '0;
        end else if (i_load || i_advance) begin
            row_q  <= row_d;
            col_q  <= col_d;
            addr_q <= i_base_addr + addr_t'(row_d * i_n + col_d);  // base + row*n + col
        end
    end

    assign o_addr = addr_q;

endmodule

`default_nettype wire

//--- verilog/display_ctrl.sv
`default_nettype none

`include "display_consts.svh"

module display_ctrl
    import display_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_en_display,
    input  disp_mode_t i_disp_mode,
    input  word_t      i_scalar,
    input  word_t      i_rdata,
    input  logic       i_tx_ready,
    input  logic       i_last_col,
    input  logic       i_last_row,
    input  char_t      i_fmt_char,
    input  logic       i_fmt_char_en,
    input  logic       i_fmt_done,
    output logic       o_walk_load,
    output logic       o_walk_advance,
    output logic       o_fmt_start,
    output word_t      o_fmt_value,
    output logic       o_fmt_pad_en,
    output logic       o_tx_en,
    output char_t      o_tx_data,
    output logic       o_disp_done
);

    typedef enum logic [3:0] {
        S_IDLE, S_INIT, S_PRE_CR, S_PRE_LF, S_FETCH_WAIT, S_SAMPLE, S_FORMAT,
        S_SEP, S_ROW_CR, S_ROW_LF, S_SCALAR_FMT, S_SCALAR_CR, S_SCALAR_LF, S_DONE
    } ctrl_state_t;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        punct_en;
    char_t       punct_chr;
    logic        load_d;
    logic        adv_d;
    logic        start_d;
    logic        wait_q;      // second fetch wait cycle
    logic        tx_en_q;
    char_t       tx_data_q;
    logic        load_q;
    logic        adv_q;
    logic        start_q;
    word_t       fmt_value_q;
    logic        fmt_pad_q;
    logic        fmt_active;

    // ====================
    // next state
    // ====================
    always_comb begin
        state_d   = state_q;
        punct_en  = 1'b0;
        punct_chr = `DISP_ASC_SPACE;
        load_d    = 1'b0;
        adv_d     = 1'b0;
        start_d   = 1'b0;
        case (state_q)
            S_IDLE: if (i_en_display) state_d = S_INIT;
            S_INIT: begin
                case (i_disp_mode)
                    MODE_MATRIX: state_d = S_PRE_CR;
                    MODE_SCALAR: begin
                        start_d = 1'b1;
                        state_d = S_SCALAR_FMT;
                    end
                    default: state_d = S_DONE;  // nothing to print
                endcase
            end
            S_PRE_CR: begin
                if (i_tx_ready) begin
                    punct_en  = 1'b1;
                    punct_chr = `DISP_ASC_CR;
                    state_d   = S_PRE_LF;
                end
            end
            S_PRE_LF: begin
                if (i_tx_ready) begin
                    punct_en  = 1'b1;
                    punct_chr = `DISP_ASC_LF;
                    load_d    = 1'b1;           // walker back to row 0, col 0
                    state_d   = S_FETCH_WAIT;
                end
            end
            S_FETCH_WAIT: if (wait_q) state_d = S_SAMPLE;
            S_SAMPLE: begin
                start_d = 1'b1;
                state_d = S_FORMAT;
            end
            S_FORMAT: if (i_fmt_done) state_d = S_SEP;
            S_SEP: begin
                if (i_last_col) begin
                    state_d = S_ROW_CR;
                end else if (i_tx_ready) begin
                    punct_en = 1'b1;
                    adv_d    = 1'b1;
                    state_d  = S_FETCH_WAIT;
                end
            end
            S_ROW_CR: begin
                if (i_tx_ready) begin
                    punct_en  = 1'b1;
                    punct_chr = `DISP_ASC_CR;
                    state_d   = S_ROW_LF;
                end
            end
            S_ROW_LF: begin
                if (i_tx_ready) begin
                    punct_en  = 1'b1;
                    punct_chr = `DISP_ASC_LF;
                    adv_d     = ~i_last_row;
                    state_d   = i_last_row ? S_DONE : S_FETCH_WAIT;
                end
            end
            S_SCALAR_FMT: if (i_fmt_done) state_d = S_SCALAR_CR;
            S_SCALAR_CR: begin
                if (i_tx_ready) begin
                    punct_en  = 1'b1;
                    punct_chr = `DISP_ASC_CR;
                    state_d   = S_SCALAR_LF;
                end
            end
            S_SCALAR_LF: begin
                if (i_tx_ready) begin
                    punct_en  = 1'b1;
                    punct_chr = `DISP_ASC_LF;
                    state_d   = S_DONE;
                end
            end
            S_DONE: if (!i_en_display) state_d = S_IDLE;  // wait for enable to drop
            default: state_d = S_IDLE;
        endcase
    end

    // ====================
    // registers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            wait_q  <= 1'b0;
            tx_en_q <= 1'b0;
            load_q  <= 1'b0;
            adv_q   <= 1'b0;
            start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            wait_q  <= (state_q == S_FETCH_WAIT) ? ~wait_q : 1'b0;
            tx_en_q <= punct_en;
            load_q  <= load_d;
            adv_q   <= adv_d;
            start_q <= start_d;
        end
    end

    // one element in flight
    always_ff @(posedge clk) begin
        if (punct_en) tx_data_q <= punct_chr;
        if (state_q == S_INIT) begin
            fmt_value_q <= i_scalar;
            fmt_pad_q   <= 1'b0;
        end else if (state_q == S_SAMPLE) begin
            fmt_value_q <= i_rdata;
            fmt_pad_q   <= 1'b1;
        end
    end

    // formatter owns the uart while a number is printed
    assign fmt_active = (state_q == S_FORMAT) || (state_q == S_SCALAR_FMT);

    assign o_tx_en        = fmt_active ? i_fmt_char_en : tx_en_q;
    assign o_tx_data      = fmt_active ? i_fmt_char : tx_data_q;
    assign o_walk_load    = load_q;
    assign o_walk_advance = adv_q;
    assign o_fmt_start    = start_q;
    assign o_fmt_value    = fmt_value_q;
    assign o_fmt_pad_en   = fmt_pad_q;
    assign o_disp_done    = (state_q == S_DONE);

endmodule

`default_nettype wire

//--- verilog/display_top.sv
`default_nettype none

module display_top
    import display_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_en_display,
    input  disp_mode_t i_disp_mode,
    input  word_t      i_disp_m,
    input  word_t      i_disp_n,
    input  addr_t      i_disp_base_addr,
    input  word_t      i_storage_rdata,
    output addr_t      o_storage_addr,
    output logic       o_uart_tx,
    output logic       o_disp_done
);

    logic  walk_load;
    logic  walk_advance;
    logic  last_col;
    logic  last_row;
    logic  fmt_start;
    word_t fmt_value;
    logic  fmt_pad_en;
    char_t fmt_char;
    logic  fmt_char_en;
    logic  fmt_done;
    logic  tx_en;
    char_t tx_data;
    logic  tx_ready;

    display_ctrl u_display_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_en_display   (i_en_display),
        .i_disp_mode    (i_disp_mode),
        .i_scalar       (i_disp_m),          // scalar rides on the row count
        .i_rdata        (i_storage_rdata),
        .i_tx_ready     (tx_ready),
        .i_last_col     (last_col),
        .i_last_row     (last_row),
        .i_fmt_char     (fmt_char),
        .i_fmt_char_en  (fmt_char_en),
        .i_fmt_done     (fmt_done),
        .o_walk_load    (walk_load),
        .o_walk_advance (walk_advance),
        .o_fmt_start    (fmt_start),
        .o_fmt_value    (fmt_value),
        .o_fmt_pad_en   (fmt_pad_en),
        .o_tx_en        (tx_en),
        .o_tx_data      (tx_data),
        .o_disp_done    (o_disp_done)
    );

    matrix_walker u_matrix_walker (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_load      (walk_load),
        .i_advance   (walk_advance),
        .i_base_addr (i_disp_base_addr),
        .i_n         (i_disp_n),
        .i_m         (i_disp_m),
        .o_addr      (o_storage_addr),
        .o_last_col  (last_col),
        .o_last_row  (last_row)
    );

    dec_formatter u_dec_formatter (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_start    (fmt_start),
        .i_value    (fmt_value),
        .i_pad_en   (fmt_pad_en),
        .i_tx_ready (tx_ready),
        .o_char     (fmt_char),
        .o_char_en  (fmt_char_en),
        .o_done     (fmt_done)
    );

    uart_tx u_uart_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_tx_en   (tx_en),
        .i_tx_data (tx_data),
        .o_tx      (o_uart_tx),
        .o_ready   (tx_ready)
    );

endmodule

`default_nettype wire

//--- tests/uart_rx_model.sv
`default_nettype none

`include "display_consts.svh"

module uart_rx_model
    import display_pkg::*;
#(
    parameter int CLKS_PER_BIT = `DISP_CLKS_PER_BIT
) (
    input  logic  clk,
    input  logic  i_rx,
    output char_t o_data,
    output logic  o_valid,      // one clock wide, set on a falling edge
    output logic  o_frame_err
);

    timeunit 1ns;
    timeprecision 100ps;

    char_t shift;
    int    i;

    // line sampled on falling edges, well away from the tx updates
    initial begin
        o_data      = '0;
        o_valid     = 1'b0;
        o_frame_err = 1'b0;
        forever begin
            @(negedge clk);
            o_valid     = 1'b0;
            o_frame_err = 1'b0;
            if (i_rx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk);  // middle of start bit
                for (i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    shift[i] = i_rx;                       // lsb first
                end
                repeat (CLKS_PER_BIT) @(negedge clk);      // middle of stop bit
                o_data      = shift;
                o_valid     = 1'b1;
                o_frame_err = (i_rx !== 1'b1);
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/display_tb.sv
`default_nettype none

`include "display_consts.svh"

module display_tb
    import display_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;

    logic       clk;
    logic       rst_n;
    logic       en_r;
    disp_mode_t mode_r;
    word_t      m_r;
    word_t      n_r;
    addr_t      base_r;
    word_t      rdata = '0;
    addr_t      addr;
    logic       tx;
    logic       done;
    char_t      rx_data;
    logic       rx_valid;
    logic       rx_frame_err;

    word_t  mem [512];
    char_t  exp_q [$];
    char_t  rx_q [$];
    int     errors = 0;
    integer seed = 32'haca8_bccb;
    word_t  scalar_vals [4] = '{32'd0, 32'd7, 32'd1234, 32'hFFFF_FFFF};

    display_top u_display_top (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_en_display     (en_r),
        .i_disp_mode      (mode_r),
        .i_disp_m         (m_r),
        .i_disp_n         (n_r),
        .i_disp_base_addr (base_r),
        .i_storage_rdata  (rdata),
        .o_storage_addr   (addr),
        .o_uart_tx        (tx),
        .o_disp_done      (done)
    );

    uart_rx_model u_uart_rx_model (
        .clk         (clk),
        .i_rx        (tx),
        .o_data      (rx_data),
        .o_valid     (rx_valid),
        .o_frame_err (rx_frame_err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // storage with one cycle of read latency
    always @(posedge clk) rdata <= mem[addr];

    always @(posedge clk) begin
        if (rx_valid) rx_q.push_back(rx_data);
        assert (!rx_frame_err) else begin
            $display("serial frame received with a bad stop bit");
            errors++;
        end
    end

    // ====================
    // expected text
    // ====================
    function automatic int dec_len(input word_t value);
        int    len;
        word_t v;
        len = 1;
        v   = value;
        while (v >= 32'd10) begin
            v = v / 32'd10;
            len++;
        end
        return len;
    endfunction

    function automatic int matrix_len(input int m, input int n);
        return 2 + m * (n * `DISP_COL_WIDTH + (n - 1) + 2);  // CR LF first, then rows
    endfunction

    task automatic append_dec(input word_t value, input bit pad);
        char_t digits [$];
        word_t v;
        int    sent;
        v = value;
        do begin
            digits.push_front(char_t'(v % 32'd10) + `DISP_ASC_ZERO);
            v = v / 32'd10;
        end while (v != 32'd0);
        sent = digits.size();
        foreach (digits[k]) exp_q.push_back(digits[k]);
        while (pad && sent < `DISP_COL_WIDTH) begin
            exp_q.push_back(`DISP_ASC_SPACE);
            sent++;
        end
    endtask

    task automatic expect_scalar(input word_t value);
        exp_q.delete();
        append_dec(value, 1'b0);
        exp_q.push_back(`DISP_ASC_CR);
        exp_q.push_back(`DISP_ASC_LF);
    endtask

    task automatic expect_matrix(input word_t m, input word_t n, input addr_t base);
        word_t r;
        word_t c;
        addr_t a;
        exp_q.delete();
        exp_q.push_back(`DISP_ASC_CR);
        exp_q.push_back(`DISP_ASC_LF);
        for (r = 0; r < m; r++) begin
            for (c = 0; c < n; c++) begin
                a = base + addr_t'(r * n + c);  // wraps like a 9-bit address
                append_dec(mem[a], 1'b1);
                if (c == n - 1) begin
                    exp_q.push_back(`DISP_ASC_CR);
                    exp_q.push_back(`DISP_ASC_LF);
                end else begin
                    exp_q.push_back(`DISP_ASC_SPACE);
                end
            end
        end
    endtask

    // ====================
    // command and checks
    // ====================
    task automatic compare_text(input string name);
        int count;
        int i;
        assert (rx_q.size() == exp_q.size()) else begin
            $display("%s: expected %0d bytes but received %0d", name, exp_q.size(),
                     rx_q.size());
            errors++;
        end
        count = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
        for (i = 0; i < count; i++) begin
            assert (rx_q[i] === exp_q[i]) else begin
                $display("FAILED %s byte %0d: expected 0x%02h actual 0x%02h", name, i,
                         exp_q[i], rx_q[i]);
                errors++;
            end
        end
    endtask

    task automatic run_command(input string name, input disp_mode_t mode, input word_t m,
                               input word_t n, input addr_t base);
        bit held;
        rx_q.delete();
        @(negedge clk);
        mode_r = mode;
        m_r    = m;
        n_r    = n;
        base_r = base;
        en_r   = 1'b1;
        while (done !== 1'b1) @(negedge clk);  // watchdog bounds this
        held = 1'b1;
        // last frame may still be on the line
        repeat (12 * `DISP_CLKS_PER_BIT) begin
            @(negedge clk);
            if (done !== 1'b1) held = 1'b0;
        end
        assert (held) else begin
            $display("%s: done dropped while enable was still high", name);
            errors++;
        end
        en_r = 1'b0;
        @(negedge clk);
        assert (done === 1'b0) else begin
            $display("%s: done still high one cycle after enable dropped", name);
            errors++;
        end
        compare_text(name);
    endtask

    initial begin : watchdog
        int     total;
        longint limit_ns;
        total = 0;
        foreach (scalar_vals[k]) total += dec_len(scalar_vals[k]) + 2;
        total += dec_len(32'd905) + 2;
        total += matrix_len(3, 4) + matrix_len(1, 1);
        limit_ns = longint'(total) * 10 * `DISP_CLKS_PER_BIT * CLK_PERIOD * 2;
        #(limit_ns);
        $display("timeout: run did not finish within %0d ns", limit_ns);
        $display("Verification failed");
        $finish;
    end

    initial begin : stimulus
        int    i;
        addr_t rand_base;
        rst_n  = 1'b0;
        en_r   = 1'b0;
        mode_r = MODE_MATRIX;
        m_r    = '0;
        n_r    = '0;
        base_r = '0;
        // spread of digit counts, tied to the address
        for (i = 0; i < 512; i++) begin
            mem[i] = (word_t'($random(seed)) >> (i % 32)) ^ word_t'(i);
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        repeat (4) begin
            @(negedge clk);
            assert (tx === 1'b1) else begin
                $display("FAILED reset_idle: o_uart_tx expected 1 actual %b", tx);
                errors++;
            end
            assert (done === 1'b0) else begin
                $display("FAILED reset_idle: o_disp_done expected 0 actual %b", done);
                errors++;
            end
        end

        foreach (scalar_vals[k]) begin
            expect_scalar(scalar_vals[k]);
            run_command($sformatf("scalar_%0d", k), MODE_SCALAR, scalar_vals[k], '0, '0);
        end

        expect_matrix(32'd3, 32'd4, 9'd40);
        run_command("matrix_3x4", MODE_MATRIX, 32'd3, 32'd4, 9'd40);

        rand_base = addr_t'($random(seed));
        expect_matrix(32'd1, 32'd1, rand_base);
        run_command("matrix_1x1", MODE_MATRIX, 32'd1, 32'd1, rand_base);

        exp_q.delete();  // nothing on the line
        run_command("unsupported_mode", disp_mode_t'(3'd2), 32'd3, 32'd4, 9'd40);

        expect_scalar(32'd905);
        run_command("scalar_after_unsupported", MODE_SCALAR, 32'd905, '0, '0);

        $display("checks complete, errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
verilog/display_pkg.sv
verilog/uart_tx.sv
verilog/dec_formatter.sv
verilog/matrix_walker.sv
verilog/display_ctrl.sv
verilog/display_top.sv
tests/uart_rx_model.sv
tests/display_tb.sv
